//--- hdl/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // --------------------------------------------------
  // Widths and basic types
  // --------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned BeWidth   = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // --------------------------------------------------
  // Address map
  // --------------------------------------------------
  typedef enum logic [1:0] {
    RegionRom   = 2'd0,
    RegionClint = 2'd1,
    RegionSpm   = 2'd2
  } region_e;

  localparam int unsigned NumRegions = 3;

  // End address is exclusive
  typedef struct packed {
    region_e idx;
    addr_t   start_addr;
    addr_t   end_addr;
  } addr_rule_t;

  localparam addr_t RomBase     = 32'h0001_0000;
  localparam addr_t RomLength   = 32'h0000_1000;
  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h0000_C000;
  localparam addr_t SpmBase     = 32'h1C00_0000;
  localparam addr_t SpmLength   = 32'h0000_8000;

  localparam addr_rule_t AddrMap [NumRegions] = '{
    '{idx: RegionRom,   start_addr: RomBase,   end_addr: RomBase + RomLength},
    '{idx: RegionClint, start_addr: ClintBase, end_addr: ClintBase + ClintLength},
    '{idx: RegionSpm,   start_addr: SpmBase,   end_addr: SpmBase + SpmLength}
  };

  // --------------------------------------------------
  // Boot ROM image, two instructions per word
  // --------------------------------------------------
  localparam int unsigned BootRomDepth = 16;

  localparam data_t BootRomImage [BootRomDepth] = '{
    64'h0010_0293_F140_2573, 64'h0202_8293_0000_0597,
    64'h0005_8593_1C00_0137, 64'h0000_0013_0001_0113,
    64'h3052_9073_0000_0297, 64'h0000_0013_0000_0013,
    64'h1050_0073_0000_006F, 64'h0000_0013_0000_0013,
    64'hDEAD_BEEF_CAFE_F00D, 64'h0123_4567_89AB_CDEF,
    64'hFEDC_BA98_7654_3210, 64'h5555_AAAA_3333_CCCC,
    64'h0F0F_F0F0_A5A5_5A5A, 64'h8000_0000_0000_0001,
    64'h0000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF
  };

  // --------------------------------------------------
  // Scratchpad and CLINT
  // --------------------------------------------------
  localparam int unsigned SpmDepth = 4096;

  localparam addr_t ClintMsipOffset     = 32'h0000_0000;
  localparam addr_t ClintMtimecmpOffset = 32'h0000_4000;
  localparam addr_t ClintMtimeOffset    = 32'h0000_BFF8;

  localparam int unsigned RtcSyncStages = 2;

  // Debug request mask window after reset, in clk_i cycles
  localparam int unsigned DebugDelayCycles = 500;
  localparam int unsigned DebugCntWidth    = $clog2(DebugDelayCycles + 1);

endpackage

`default_nettype wire

//--- hdl/addr_demux.sv
`timescale 1ns/1ps
`default_nettype none

module addr_demux (
  input  logic            clk_i,
  input  logic            ndmreset_n,
  input  logic            req_i,
  input  logic            we_i,
  input  soc_pkg::addr_t  addr_i,
  input  soc_pkg::data_t  wdata_i,
  input  soc_pkg::be_t    be_i,
  input  soc_pkg::data_t  rom_rdata_i,
  input  soc_pkg::data_t  clint_rdata_i,
  input  soc_pkg::data_t  spm_rdata_i,
  output logic            rom_req_o,
  output logic            clint_req_o,
  output logic            spm_req_o,
  output logic            rvalid_o,
  output soc_pkg::data_t  rdata_o,
  output logic            err_o
);
  import soc_pkg::*;

  logic [NumRegions-1:0] hit;
  region_e               sel_d;
  region_e               sel_q;
  logic                  miss_q;
  logic                  we_q;
  logic                  rvalid_q;

  // Compare against every rule, last match wins
  always_comb begin
    hit   = '0;
    sel_d = RegionRom;
    for (int unsigned i = 0; i < NumRegions; i++) begin
      if (addr_i >= AddrMap[i].start_addr && addr_i < AddrMap[i].end_addr) begin
        hit[AddrMap[i].idx] = 1'b1;
        sel_d               = AddrMap[i].idx;
      end
    end
  end

  assign rom_req_o   = req_i & hit[RegionRom];
  assign clint_req_o = req_i & hit[RegionClint];
  assign spm_req_o   = req_i & hit[RegionSpm];

  // Remember where the response comes from
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
      miss_q   <= 1'b0;
      we_q     <= 1'b0;
      sel_q    <= RegionRom;
    end else begin
      rvalid_q <= req_i;
      if (req_i) begin
        miss_q <= (hit == '0);
        we_q   <= we_i;
        sel_q  <= sel_d;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = rvalid_q & miss_q;

  // Write data and strobes are shared, only the response is muxed
  always_comb begin
    rdata_o = '0;
    if (rvalid_q && !miss_q && !we_q) begin
      case (sel_q)
        RegionRom:   rdata_o = rom_rdata_i;
        RegionClint: rdata_o = clint_rdata_i;
        RegionSpm:   rdata_o = spm_rdata_i;
        default:     rdata_o = '0;
      endcase
    end
  end

  a_onehot_targets : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    $onehot0({rom_req_o, clint_req_o, spm_req_o}));

endmodule

`default_nettype wire

//--- hdl/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  logic            clk_i,
  input  logic            ndmreset_n,
  input  logic            req_i,
  input  soc_pkg::addr_t  addr_i,
  output soc_pkg::data_t  rdata_o
);
  import soc_pkg::*;

  logic [$clog2(BootRomDepth)-1:0] word_idx;
  data_t                           rdata_q;

  // Word index wraps modulo the image depth
  assign word_idx = addr_i[$clog2(BeWidth) +: $clog2(BootRomDepth)];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rdata_q <= '0;
    end else if (req_i) begin
      rdata_q <= BootRomImage[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- hdl/spm_ram.sv
`timescale 1ns/1ps
`default_nettype none

module spm_ram #(
  parameter int unsigned NumWords = soc_pkg::SpmDepth
) (
  input  logic            clk_i,
  input  logic            ndmreset_n,
  input  logic            req_i,
  input  logic            we_i,
  input  soc_pkg::addr_t  addr_i,
  input  soc_pkg::data_t  wdata_i,
  input  soc_pkg::be_t    be_i,
  output soc_pkg::data_t  rdata_o
);
  import soc_pkg::*;

  localparam int unsigned IdxWidth = (NumWords > 1) ? $clog2(NumWords) : 1;

  data_t                mem [NumWords];
  logic [IdxWidth-1:0]  word_idx;
  data_t                rdata_q;

  assign word_idx = addr_i[$clog2(BeWidth) +: IdxWidth];

  // Byte lane writes
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (be_i[b]) begin
          mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem[word_idx];
    end
  end

  assign rdata_o = rdata_q;

  a_idx_in_range : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    req_i |-> (word_idx < NumWords));

endmodule

`default_nettype wire

//--- hdl/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  logic            clk_i,
  input  logic            ndmreset_n,
  input  logic            rtc_i,
  input  logic            req_i,
  input  logic            we_i,
  input  soc_pkg::addr_t  addr_i,
  input  soc_pkg::data_t  wdata_i,
  input  soc_pkg::be_t    be_i,
  output soc_pkg::data_t  rdata_o,
  output logic            timer_irq_o,
  output logic            ipi_o
);
  import soc_pkg::*;

  logic [RtcSyncStages-1:0] rtc_sync_q;
  logic                     rtc_prev_q;
  logic                     rtc_toggle_q;
  logic                     rtc_rise;
  logic                     mtime_tick;
  logic                     sel_msip;
  logic                     sel_mtimecmp;
  logic                     sel_mtime;
  logic                     mtime_wr;
  logic                     msip_q;
  data_t                    mtime_q;
  data_t                    mtimecmp_q;
  data_t                    rdata_q;

  function automatic data_t apply_be(data_t old_val, data_t new_val, be_t be);
    data_t res;
    res = old_val;
    for (int unsigned b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // --------------------------------------------------
  // RTC timebase, half the RTC rate
  // --------------------------------------------------
  assign rtc_rise   = rtc_sync_q[RtcSyncStages-1] & ~rtc_prev_q;
  assign mtime_tick = rtc_rise & rtc_toggle_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q   <= '0;
      rtc_prev_q   <= 1'b0;
      rtc_toggle_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[RtcSyncStages-2:0], rtc_i};
      rtc_prev_q <= rtc_sync_q[RtcSyncStages-1];
      if (rtc_rise) begin
        rtc_toggle_q <= ~rtc_toggle_q;
      end
    end
  end

  // --------------------------------------------------
  // Register file
  // --------------------------------------------------
  // Decode on the 8-byte word inside the CLINT window
  assign sel_msip     = (addr_i[15:3] == ClintMsipOffset[15:3]);
  assign sel_mtimecmp = (addr_i[15:3] == ClintMtimecmpOffset[15:3]);
  assign sel_mtime    = (addr_i[15:3] == ClintMtimeOffset[15:3]);
  assign mtime_wr     = req_i & we_i & sel_mtime;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
      rdata_q    <= '0;
    end else begin
      if (req_i && we_i && sel_msip && be_i[0]) begin
        msip_q <= wdata_i[0];
      end
      if (req_i && we_i && sel_mtimecmp) begin
        mtimecmp_q <= apply_be(mtimecmp_q, wdata_i, be_i);
      end
      // Software write takes priority over the tick
      if (mtime_wr) begin
        mtime_q <= apply_be(mtime_q, wdata_i, be_i);
      end else if (mtime_tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (req_i && !we_i) begin
        if (sel_msip) begin
          rdata_q <= {{(DataWidth-1){1'b0}}, msip_q};
        end else if (sel_mtimecmp) begin
          rdata_q <= mtimecmp_q;
        end else if (sel_mtime) begin
          rdata_q <= mtime_q;
        end else begin
          rdata_q <= '0;
        end
      end
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

  a_mtime_monotonic : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !mtime_wr |=> (mtime_q >= $past(mtime_q)));

endmodule

`default_nettype wire

//--- hdl/debug_req_gate.sv
`timescale 1ns/1ps
`default_nettype none

module debug_req_gate (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);
  import soc_pkg::*;

  logic [DebugCntWidth-1:0] cnt_q;

  // Boot code runs first, requests held off until the count drains
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= DebugCntWidth'(DebugDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) & debug_req_i;

endmodule

`default_nettype wire

//--- hdl/soc_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module soc_subsystem (
  input  logic            clk_i,
  input  logic            ndmreset_n,
  input  logic            rtc_i,
  input  logic            req_i,
  input  logic            we_i,
  input  soc_pkg::addr_t  addr_i,
  input  soc_pkg::data_t  wdata_i,
  input  soc_pkg::be_t    be_i,
  input  logic            debug_req_i,
  output logic            rvalid_o,
  output soc_pkg::data_t  rdata_o,
  output logic            err_o,
  output logic            timer_irq_o,
  output logic            ipi_o,
  output logic            debug_req_o
);
  import soc_pkg::*;

  logic  rom_req;
  logic  clint_req;
  logic  spm_req;
  data_t rom_rdata;
  data_t clint_rdata;
  data_t spm_rdata;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  addr_demux i_addr_demux (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_i         ( req_i       ),
    .we_i          ( we_i        ),
    .addr_i        ( addr_i      ),
    .wdata_i       ( wdata_i     ),
    .be_i          ( be_i        ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .spm_rdata_i   ( spm_rdata   ),
    .rom_req_o     ( rom_req     ),
    .clint_req_o   ( clint_req   ),
    .spm_req_o     ( spm_req     ),
    .rvalid_o      ( rvalid_o    ),
    .rdata_o       ( rdata_o     ),
    .err_o         ( err_o       )
  );

  // --------------------------------------------------
  // Targets
  // --------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( rom_req    ),
    .addr_i     ( addr_i     ),
    .rdata_o    ( rom_rdata  )
  );

  spm_ram #(
    .NumWords ( SpmDepth )
  ) i_spm_ram (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( spm_req    ),
    .we_i       ( we_i       ),
    .addr_i     ( addr_i     ),
    .wdata_i    ( wdata_i    ),
    .be_i       ( be_i       ),
    .rdata_o    ( spm_rdata  )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .wdata_i     ( wdata_i     ),
    .be_i        ( be_i        ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // Debug request hold-off
  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

//--- testbench/tb_soc_ref.svh
`ifndef TB_SOC_REF_SVH
`define TB_SOC_REF_SVH

// Model state for the scratchpad and the CLINT registers
data_t       spm_model [SpmDepth];
logic        msip_model;
data_t       mtimecmp_model;
data_t       mtime_model;
logic [31:0] lfsr_state;

// --------------------------------------------------
// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
// --------------------------------------------------
function automatic logic [63:0] rand_bits(int unsigned n);
  logic [63:0] val;
  logic        fb;
  val = '0;
  for (int unsigned i = 0; i < n; i++) begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    val        = {val[62:0], fb};
  end
  return val;
endfunction

function automatic data_t lane_merge(data_t old_val, data_t new_val, be_t be);
  data_t res;
  res = old_val;
  for (int unsigned b = 0; b < BeWidth; b++) begin
    if (be[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
  end
  return res;
endfunction

// Expected {err, rdata} for one request, updates the model on writes
function automatic logic [DataWidth:0] ref_access(logic we, addr_t addr, data_t wdata, be_t be);
  data_t       rdata;
  int unsigned word;
  rdata = '0;
  if (addr >= RomBase && addr < RomBase + RomLength) begin
    if (!we) rdata = BootRomImage[((addr - RomBase) >> 3) % BootRomDepth];
  end else if (addr >= SpmBase && addr < SpmBase + SpmLength) begin
    word = (addr - SpmBase) >> 3;
    if (we) spm_model[word] = lane_merge(spm_model[word], wdata, be);
    else rdata = spm_model[word];
  end else if (addr >= ClintBase && addr < ClintBase + ClintLength) begin
    word = (addr - ClintBase) >> 3;
    if (word == (ClintMsipOffset >> 3)) begin
      if (we && be[0]) msip_model = wdata[0];
      if (!we) rdata = {63'd0, msip_model};
    end else if (word == (ClintMtimecmpOffset >> 3)) begin
      if (we) mtimecmp_model = lane_merge(mtimecmp_model, wdata, be);
      else rdata = mtimecmp_model;
    end else if (word == (ClintMtimeOffset >> 3)) begin
      if (we) mtime_model = lane_merge(mtime_model, wdata, be);
      else rdata = mtime_model;
    end
  end else begin
    return {1'b1, {DataWidth{1'b0}}};
  end
  return {1'b0, rdata};
endfunction

task automatic check_equal(string name, logic [63:0] expected, logic [63:0] actual);
  if (actual !== expected) begin
    stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
  end
endtask

`endif

//--- testbench/tb_soc_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_subsystem;
  import soc_pkg::*;

  localparam int unsigned RtcTicks     = 4;
  localparam int unsigned SpmWindow    = 64;
  localparam int unsigned SpmRandomOps = 200;
  localparam int unsigned TestCycles   = 8 + 40 + SpmWindow + SpmRandomOps + 30 + 60
                                         + RtcTicks * 32 + 30 + DebugDelayCycles + 10;

  logic  clk_i;
  logic  ndmreset_n;
  logic  rtc_i;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  data_t wdata_i;
  be_t   be_i;
  logic  debug_req_i;
  logic  rvalid_o;
  data_t rdata_o;
  logic  err_o;
  logic  timer_irq_o;
  logic  ipi_o;
  logic  debug_req_o;

  // Expected responses in issue order
  logic [DataWidth:0] exp_q [$];
  string              name_q [$];
  logic               req_pending;

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  `include "tb_soc_ref.svh"

  soc_subsystem UUT (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .wdata_i     ( wdata_i     ),
    .be_i        ( be_i        ),
    .debug_req_i ( debug_req_i ),
    .rvalid_o    ( rvalid_o    ),
    .rdata_o     ( rdata_o     ),
    .err_o       ( err_o       ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_o ( debug_req_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    repeat (2 * TestCycles) @(posedge clk_i);
    stop_on_error("TIMEOUT: the test sequence did not finish in time");
  end

  // --------------------------------------------------
  // Response checker, samples on the falling edge
  // --------------------------------------------------
  always @(negedge clk_i) begin : response_check
    logic [DataWidth:0] exp_val;
    string              exp_name;
    if (ndmreset_n) begin
      if (req_pending && !rvalid_o) begin
        stop_on_error("No response: rvalid_o stayed low one cycle after a request");
      end else if (!req_pending && rvalid_o) begin
        stop_on_error("Unexpected response: rvalid_o rose without a request");
      end else if (rvalid_o) begin
        exp_val  = exp_q.pop_front();
        exp_name = name_q.pop_front();
        check_equal({exp_name, " rdata"}, exp_val[DataWidth-1:0], rdata_o);
        check_equal({exp_name, " err"}, exp_val[DataWidth], err_o);
      end
    end
    req_pending = ndmreset_n & req_i;
  end

  task automatic issue(string name, logic we, addr_t addr, data_t wdata, be_t be);
    exp_q.push_back(ref_access(we, addr, wdata, be));
    name_q.push_back(name);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    be_i    <= be;
  endtask

  task automatic idle();
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  task automatic check_irqs();
    @(negedge clk_i);
    check_equal("timer_irq", mtime_model >= mtimecmp_model, timer_irq_o);
    check_equal("ipi", msip_model, ipi_o);
  endtask

  task automatic test_rom();
    for (int unsigned i = 0; i < BootRomDepth; i++) begin
      issue("rom_read", 1'b0, RomBase + addr_t'(i * 8), '0, '0);
    end
    issue("rom_wrap", 1'b0, RomBase + addr_t'((BootRomDepth + 3) * 8), '0, '0);
    issue("rom_write", 1'b1, RomBase + 8, 64'h1234_5678_9ABC_DEF0, '1);
    issue("rom_after_write", 1'b0, RomBase + 8, '0, '0);
    idle();
  endtask

  task automatic test_spm();
    logic  we;
    addr_t addr;
    data_t wdata;
    be_t   be;
    // Fill a window so random reads never hit unwritten words
    for (int unsigned i = 0; i < SpmWindow; i++) begin
      issue("spm_fill", 1'b1, SpmBase + addr_t'(i * 8), rand_bits(64), '1);
    end
    for (int unsigned n = 0; n < SpmRandomOps; n++) begin
      we    = 1'(rand_bits(1));
      addr  = SpmBase + addr_t'(rand_bits(6) << 3);
      wdata = rand_bits(64);
      be    = be_t'(rand_bits(8));
      issue("spm_random", we, addr, wdata, be);
    end
    idle();
  endtask

  task automatic test_decode_errors();
    addr_t bad [6] = '{32'h0000_0000, RomBase + RomLength, ClintBase - 8,
                       ClintBase + ClintLength, SpmBase + SpmLength, 32'hFFFF_FFF8};
    foreach (bad[i]) begin
      issue("decode_err_write", 1'b1, bad[i], '1, '1);
      issue("decode_err_read", 1'b0, bad[i], '0, '0);
    end
    // SpmBase + SpmLength would alias word 0 if it were decoded
    issue("spm_after_err", 1'b0, SpmBase, '0, '0);
    issue("msip_after_err", 1'b0, ClintBase + ClintMsipOffset, '0, '0);
    idle();
  endtask

  task automatic test_clint();
    addr_t mtimecmp_addr = ClintBase + ClintMtimecmpOffset;
    addr_t mtime_addr    = ClintBase + ClintMtimeOffset;
    addr_t msip_addr     = ClintBase + ClintMsipOffset;
    check_irqs();
    issue("mtimecmp_wr", 1'b1, mtimecmp_addr, 64'd100, '1);
    idle();
    check_irqs();
    issue("mtime_wr_low", 1'b1, mtime_addr, 64'd50, '1);
    idle();
    check_irqs();
    issue("mtime_wr_equal", 1'b1, mtime_addr, 64'd100, '1);
    idle();
    check_irqs();
    issue("mtimecmp_wr_high", 1'b1, mtimecmp_addr, 64'd200, '1);
    idle();
    check_irqs();
    // Low byte only
    issue("mtimecmp_wr_byte", 1'b1, mtimecmp_addr, 64'hFFFF_FFFF_FFFF_FF10, 8'h01);
    idle();
    check_irqs();
    issue("mtimecmp_rd", 1'b0, mtimecmp_addr, '0, '0);
    issue("mtime_rd", 1'b0, mtime_addr, '0, '0);
    issue("msip_set", 1'b1, msip_addr, 64'd1, '1);
    idle();
    check_irqs();
    issue("msip_rd", 1'b0, msip_addr, '0, '0);
    issue("msip_clear", 1'b1, msip_addr, 64'd0, '1);
    idle();
    check_irqs();
    issue("clint_unknown_wr", 1'b1, ClintBase + 32'h100, '1, '1);
    issue("clint_unknown_rd", 1'b0, ClintBase + 32'h100, '0, '0);
    idle();
  endtask

  task automatic test_rtc_divider();
    addr_t mtime_addr = ClintBase + ClintMtimeOffset;
    issue("mtime_set", 1'b1, mtime_addr, 64'h1000, '1);
    idle();
    // Two rising RTC edges per mtime tick
    repeat (4 * RtcTicks) begin
      repeat (8) @(posedge clk_i);
      rtc_i <= ~rtc_i;
    end
    repeat (10) @(posedge clk_i);
    mtime_model = mtime_model + RtcTicks;
    issue("mtime_after_rtc", 1'b0, mtime_addr, '0, '0);
    idle();
  endtask

  task automatic check_debug_window();
    for (int unsigned i = 1; i <= DebugDelayCycles + 5; i++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_equal("debug_window", i >= DebugDelayCycles, debug_req_o);
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    ndmreset_n     = 1'b0;
    rtc_i          = 1'b0;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    wdata_i        = '0;
    be_i           = '0;
    debug_req_i    = 1'b1;
    req_pending    = 1'b0;
    msip_model     = 1'b0;
    mtimecmp_model = '1;
    mtime_model    = '0;
    lfsr_state     = 32'd83286;
    repeat (8) @(posedge clk_i);
    ndmreset_n <= 1'b1;
    fork
      check_debug_window();
      begin
        test_rom();
        test_spm();
        test_decode_errors();
        test_clint();
        test_rtc_divider();
      end
    join
    repeat (3) @(posedge clk_i);
    if (exp_q.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_on_error($sformatf("%0d requests never got a response", exp_q.size()));
    end
  end

endmodule

`default_nettype wire

//--- soc_subsystem.f
+incdir+testbench
hdl/soc_pkg.sv
hdl/addr_demux.sv
hdl/boot_rom.sv
hdl/spm_ram.sv
hdl/clint_timer.sv
hdl/debug_req_gate.sv
hdl/soc_subsystem.sv
testbench/tb_soc_subsystem.sv

//--- Bender.yml
package:
  name: soc_subsystem

sources:
  - files:
      - hdl/soc_pkg.sv
      - hdl/addr_demux.sv
      - hdl/boot_rom.sv
      - hdl/spm_ram.sv
      - hdl/clint_timer.sv
      - hdl/debug_req_gate.sv
      - hdl/soc_subsystem.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_soc_subsystem.sv
